/* verilog/isaPkg.sv */
package isaPkg;

   localparam int NumRegs = 8;
   localparam int RomDepth = 256;

   typedef enum logic [3:0] {
      NOP,
      STO,
      ADD,
      SHL,
      BLE,
      JMP,
      CALL,
      RET,
      LCD_CMD,
      LCD_CHAR,
      LCD_ENB,
      HALT
   } opcodeT;

   typedef logic [7:0] regIdxT;   // Only low 3 bits decoded

   localparam regIdxT R0 = 8'd0;
   localparam regIdxT R1 = 8'd1;   // Wait inner counter
   localparam regIdxT R2 = 8'd2;   // Constant one
   localparam regIdxT R3 = 8'd3;   // Outer limit / enable count
   localparam regIdxT R4 = 8'd4;   // Inner limit
   localparam regIdxT R5 = 8'd5;   // Outer counter
   localparam regIdxT R6 = 8'd6;   // LCD data byte
   localparam regIdxT R7 = 8'd7;   // Constant four, nibble shift

   typedef struct packed {
      opcodeT      op;
      logic [7:0]  dst;
      logic [15:0] imm;
   } immFieldsT;

   typedef struct packed {
      opcodeT     op;
      logic [7:0] dst;
      regIdxT     srcA;
      regIdxT     srcB;
   } regFieldsT;

   typedef union packed {
      immFieldsT immV;
      regFieldsT regV;
   } instrT;

   // Entry points and loop heads of the ROM program
   localparam logic [7:0] LblExit = 8'd51;
   localparam logic [7:0] LblLongWait = 8'd52;
   localparam logic [7:0] LblLongLoop = 8'd54;
   localparam logic [7:0] LblShortWait = 8'd60;
   localparam logic [7:0] LblShortLoop = 8'd61;
   localparam logic [7:0] LblPutCmd = 8'd64;
   localparam logic [7:0] LblPutChar = 8'd71;
   localparam logic [7:0] LblCharSub = 8'd78;
   localparam logic [7:0] LblCmdSub = 8'd80;
   localparam logic [7:0] LblEnbPulse = 8'd81;
   localparam logic [7:0] LblEnbLoop = 8'd84;

endpackage

/* verilog/lcdPkg.sv */
package lcdPkg;

   typedef logic [3:0] lcdNibbleT;

   localparam logic [7:0] ChH = 8'h48;
   localparam logic [7:0] ChO = 8'h4F;
   localparam logic [7:0] ChL = 8'h4C;
   localparam logic [7:0] ChA = 8'h41;
   localparam logic [7:0] ChSpace = 8'h20;
   localparam logic [7:0] ChM = 8'h4D;
   localparam logic [7:0] ChU = 8'h55;
   localparam logic [7:0] ChN = 8'h4E;
   localparam logic [7:0] ChD = 8'h44;

   localparam logic [7:0] CmdWake = 8'h30;        // Power-on nibble 3
   localparam logic [7:0] CmdFourBit = 8'h20;     // Switch to 4-bit bus
   localparam logic [7:0] CmdFuncSet = 8'h28;     // Two lines, 5x8 font
   localparam logic [7:0] CmdEntryMode = 8'h06;
   localparam logic [7:0] CmdDisplayOn = 8'h0C;
   localparam logic [7:0] CmdClear = 8'h01;

   typedef enum logic [3:0] {
      CTRL     = 4'h0,
      STATUS   = 4'h4,
      LASTNIB  = 4'h8,
      NIBCOUNT = 4'hC
   } regAddrT;

   localparam logic [1:0] RespOkay = 2'b00;
   localparam logic [1:0] RespSlvErr = 2'b10;

endpackage

/* verilog/lcdBusIf.sv */
`timescale 1ns/1ps

interface lcdBusIf;

   logic        cmdWrite;    // Latch nibble with RS low
   logic        charWrite;   // Latch nibble with RS high
   logic        enbToggle;
   logic [15:0] data;        // Bits 7:4 go to the pins

   modport core (
      output cmdWrite, charWrite, enbToggle, data
   );

   modport port (
      input cmdWrite, charWrite, enbToggle, data
   );

endinterface

/* verilog/coreCtrlIf.sv */
`timescale 1ns/1ps

interface coreCtrlIf;

   logic       run;       // Low holds the core
   logic       restart;   // Single-cycle pulse
   logic       halted;
   logic [7:0] pc;

   modport core (
      input  run, restart,
      output halted, pc
   );

   modport regs (
      output run, restart,
      input  halted, pc
   );

endinterface

/* verilog/programRom.sv */
`timescale 1ns/1ps

module programRom import isaPkg::*, lcdPkg::*; #(
   parameter int WaitShift = 0
) (
   input  logic [$clog2(RomDepth)-1:0] address,
   output instrT                       instr
);

   function automatic logic [15:0] scaled(int unsigned count);
      int unsigned s;
      s = count >> WaitShift;
      return (s == 0) ? 16'd1 : s[15:0];
   endfunction

   function automatic instrT immOp(opcodeT op, logic [7:0] dst, logic [15:0] imm);
      instrT w;
      w.immV = '{op, dst, imm};
      return w;
   endfunction

   function automatic instrT regOp(opcodeT op, logic [7:0] dst, regIdxT a, regIdxT b);
      instrT w;
      w.regV = '{op, dst, a, b};
      return w;
   endfunction

   always_comb begin
      case (address)
         8'd0:  instr = immOp(STO, R2, 16'd1);
         8'd1:  instr = immOp(STO, R7, 16'd4);
         8'd2:  instr = immOp(STO, R6, {8'h00, CmdWake});
         // Power-on nibble sequence
         8'd3:  instr = immOp(STO, R3, scaled(24));
         8'd4:  instr = immOp(STO, R4, scaled(31250));
         8'd5:  instr = immOp(CALL, LblLongWait, 16'd0);     // About 15 ms
         8'd6:  instr = immOp(CALL, LblCmdSub, 16'd0);       // Nibble 3
         8'd7:  instr = immOp(STO, R3, scaled(8));
         8'd8:  instr = immOp(STO, R4, scaled(25625));
         8'd9:  instr = immOp(CALL, LblLongWait, 16'd0);
         8'd10: instr = immOp(CALL, LblCmdSub, 16'd0);       // Nibble 3
         8'd11: instr = immOp(STO, R4, scaled(5000));
         8'd12: instr = immOp(CALL, LblShortWait, 16'd0);
         8'd13: instr = immOp(CALL, LblCmdSub, 16'd0);       // Nibble 3
         8'd14: instr = immOp(STO, R4, scaled(2000));
         8'd15: instr = immOp(CALL, LblShortWait, 16'd0);
         8'd16: instr = immOp(STO, R6, {8'h00, CmdFourBit});
         8'd17: instr = immOp(CALL, LblCmdSub, 16'd0);       // Nibble 2
         8'd18: instr = immOp(STO, R4, scaled(2000));
         8'd19: instr = immOp(CALL, LblShortWait, 16'd0);
         // Full bytes from here on
         8'd20: instr = immOp(STO, R6, {8'h00, CmdFuncSet});
         8'd21: instr = immOp(CALL, LblPutCmd, 16'd0);
         8'd22: instr = immOp(STO, R6, {8'h00, CmdEntryMode});
         8'd23: instr = immOp(CALL, LblPutCmd, 16'd0);
         8'd24: instr = immOp(STO, R6, {8'h00, CmdDisplayOn});
         8'd25: instr = immOp(CALL, LblPutCmd, 16'd0);
         8'd26: instr = immOp(STO, R6, {8'h00, CmdClear});
         8'd27: instr = immOp(CALL, LblPutCmd, 16'd0);
         8'd28: instr = immOp(STO, R3, scaled(8));           // Clear needs a long wait
         8'd29: instr = immOp(STO, R4, scaled(10250));
         8'd30: instr = immOp(CALL, LblLongWait, 16'd0);
         8'd31: instr = immOp(STO, R6, {8'h00, ChH});
         8'd32: instr = immOp(CALL, LblPutChar, 16'd0);
         8'd33: instr = immOp(STO, R6, {8'h00, ChO});
         8'd34: instr = immOp(CALL, LblPutChar, 16'd0);
         8'd35: instr = immOp(STO, R6, {8'h00, ChL});
         8'd36: instr = immOp(CALL, LblPutChar, 16'd0);
         8'd37: instr = immOp(STO, R6, {8'h00, ChA});
         8'd38: instr = immOp(CALL, LblPutChar, 16'd0);
         8'd39: instr = immOp(STO, R6, {8'h00, ChSpace});
         8'd40: instr = immOp(CALL, LblPutChar, 16'd0);
         8'd41: instr = immOp(STO, R6, {8'h00, ChM});
         8'd42: instr = immOp(CALL, LblPutChar, 16'd0);
         8'd43: instr = immOp(STO, R6, {8'h00, ChU});
         8'd44: instr = immOp(CALL, LblPutChar, 16'd0);
         8'd45: instr = immOp(STO, R6, {8'h00, ChN});
         8'd46: instr = immOp(CALL, LblPutChar, 16'd0);
         8'd47: instr = immOp(STO, R6, {8'h00, ChD});
         8'd48: instr = immOp(CALL, LblPutChar, 16'd0);
         8'd49: instr = immOp(STO, R6, {8'h00, ChO});
         8'd50: instr = immOp(CALL, LblPutChar, 16'd0);
         8'd51: instr = immOp(HALT, R0, 16'd0);              // Exit, PC parks here
         // Nested wait, R4 inner limit and R3 outer limit
         8'd52: instr = immOp(STO, R1, 16'd0);
         8'd53: instr = immOp(STO, R5, 16'd0);
         8'd54: instr = regOp(ADD, R1, R1, R2);
         8'd55: instr = regOp(BLE, LblLongLoop, R1, R4);
         8'd56: instr = regOp(ADD, R5, R5, R2);
         8'd57: instr = immOp(STO, R1, 16'd0);
         8'd58: instr = regOp(BLE, LblLongLoop, R5, R3);
         8'd59: instr = immOp(RET, R0, 16'd0);
         8'd60: instr = immOp(STO, R1, 16'd0);
         8'd61: instr = regOp(ADD, R1, R1, R2);
         8'd62: instr = regOp(BLE, LblShortLoop, R1, R4);
         8'd63: instr = immOp(RET, R0, 16'd0);
         // Byte writers, high nibble then low nibble
         8'd64: instr = immOp(CALL, LblCmdSub, 16'd0);
         8'd65: instr = immOp(STO, R4, scaled(50));
         8'd66: instr = immOp(CALL, LblShortWait, 16'd0);
         8'd67: instr = regOp(SHL, R6, R6, R7);
         8'd68: instr = immOp(CALL, LblCmdSub, 16'd0);
         8'd69: instr = immOp(STO, R4, scaled(2000));
         8'd70: instr = immOp(JMP, LblShortWait, 16'd0);     // Tail call
         8'd71: instr = immOp(CALL, LblCharSub, 16'd0);
         8'd72: instr = immOp(STO, R4, scaled(50));
         8'd73: instr = immOp(CALL, LblShortWait, 16'd0);
         8'd74: instr = regOp(SHL, R6, R6, R7);
         8'd75: instr = immOp(CALL, LblCharSub, 16'd0);
         8'd76: instr = immOp(STO, R4, scaled(2000));
         8'd77: instr = immOp(JMP, LblShortWait, 16'd0);
         8'd78: instr = regOp(LCD_CHAR, R0, R6, R0);
         8'd79: instr = immOp(JMP, LblEnbPulse, 16'd0);
         8'd80: instr = regOp(LCD_CMD, R0, R6, R0);
         // Shared E pulse, 13 loop passes high
         8'd81: instr = immOp(STO, R5, 16'd0);
         8'd82: instr = immOp(STO, R3, 16'd12);
         8'd83: instr = regOp(LCD_ENB, R0, R0, R0);          // E rises
         8'd84: instr = regOp(ADD, R5, R5, R2);
         8'd85: instr = regOp(BLE, LblEnbLoop, R5, R3);
         8'd86: instr = regOp(LCD_ENB, R0, R0, R0);          // E falls, nibble taken
         8'd87: instr = immOp(RET, R0, 16'd0);
         default: instr = immOp(NOP, R0, 16'd0);
      endcase
   end

endmodule

/* verilog/seqCore.sv */
`timescale 1ns/1ps

module seqCore import isaPkg::*; #(
   parameter int StackDepth = 4
) (
   input  logic                       clk,
   input  logic                       rstN,
   output logic [$clog2(RomDepth)-1:0] pcOut,
   input  instrT                      instr,
   lcdBusIf.core                      lcdBus,
   coreCtrlIf.core                    ctrl
);

   localparam int IdxBits = $clog2(NumRegs);
   localparam int PcBits = $clog2(RomDepth);
   localparam int DepthBits = $clog2(StackDepth + 1);

   logic [PcBits-1:0]    pc;
   logic [PcBits-1:0]    pcNext;
   logic [PcBits-1:0]    pcInc;
   logic [PcBits-1:0]    target;
   logic [15:0]          rf [NumRegs];
   logic [PcBits-1:0]    stack [StackDepth];   // Entry 0 is the top
   logic [DepthBits-1:0] depth;
   logic                 halted;
   logic                 exec;
   opcodeT               op;
   logic [IdxBits-1:0]   dstIdx;
   logic [15:0]          srcA;
   logic [15:0]          srcB;

   // Both views share the opcode and the first byte
   assign op = instr.immV.op;
   assign dstIdx = instr.immV.dst[IdxBits-1:0];
   assign target = instr.regV.dst[PcBits-1:0];
   assign srcA = rf[instr.regV.srcA[IdxBits-1:0]];
   assign srcB = rf[instr.regV.srcB[IdxBits-1:0]];

   assign exec = ctrl.run && !halted && !ctrl.restart;
   assign pcInc = pc + 1'b1;

   always_comb begin
      pcNext = pcInc;
      case (op)
         BLE: begin
            if (srcA <= srcB) begin
               pcNext = target;
            end
         end
         JMP, CALL: pcNext = target;
         RET: begin
            if (depth != '0) begin   // Empty stack falls through
               pcNext = stack[0];
            end
         end
         HALT: pcNext = pc;
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstN || ctrl.restart) begin
         pc <= '0;
         depth <= '0;
         halted <= 1'b0;
      end else if (exec) begin
         pc <= pcNext;
         if (op == HALT) begin
            halted <= 1'b1;
         end
         if (op == CALL && depth != DepthBits'(StackDepth)) begin
            depth <= depth + 1'b1;   // Saturates, oldest entry falls off
         end else if (op == RET && depth != '0) begin
            depth <= depth - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (exec) begin
         case (op)
            STO: rf[dstIdx] <= instr.immV.imm;
            ADD: rf[dstIdx] <= srcA + srcB;
            SHL: rf[dstIdx] <= srcA << srcB;
            default: ;
         endcase
         if (op == CALL) begin
            stack[0] <= pcInc;
            for (int i = 1; i < StackDepth; i++) begin
               stack[i] <= stack[i-1];
            end
         end else if (op == RET) begin
            for (int i = 0; i < StackDepth - 1; i++) begin
               stack[i] <= stack[i+1];
            end
         end
      end
   end

   // One strobe per LCD opcode
   assign lcdBus.cmdWrite = exec && op == LCD_CMD;
   assign lcdBus.charWrite = exec && op == LCD_CHAR;
   assign lcdBus.enbToggle = exec && op == LCD_ENB;
   assign lcdBus.data = srcA;

   assign pcOut = pc;
   assign ctrl.pc = pc;
   assign ctrl.halted = halted;

endmodule

/* verilog/lcdPort.sv */
`timescale 1ns/1ps

module lcdPort import lcdPkg::*; (
   input  logic       clk,
   input  logic       rstN,
   lcdBusIf.port      lcdBus,
   output logic       lcdRs,
   output logic       lcdE,
   output lcdNibbleT  lcdD,
   output lcdNibbleT  lastNibble,
   output logic       lastRs,
   output logic [7:0] nibbleCount
);

   logic eFall;

   // E drops on the next edge
   assign eFall = lcdBus.enbToggle && lcdE;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         lcdRs <= 1'b0;
         lcdE <= 1'b0;
         lcdD <= '0;
         lastNibble <= '0;
         lastRs <= 1'b0;
         nibbleCount <= '0;
      end else begin
         if (lcdBus.cmdWrite || lcdBus.charWrite) begin
            lcdD <= lcdBus.data[7:4];
            lcdRs <= lcdBus.charWrite;
         end
         if (lcdBus.enbToggle) begin
            lcdE <= !lcdE;
         end
         if (eFall) begin
            lastNibble <= lcdD;   // Pins still hold the nibble being taken
            lastRs <= lcdRs;
            nibbleCount <= nibbleCount + 1'b1;   // Wraps at 256
         end
      end
   end

endmodule

/* verilog/ctrlRegs.sv */
`timescale 1ns/1ps

module ctrlRegs import lcdPkg::*; (
   input  logic        clk,
   input  logic        rstN,
   input  logic [7:0]  awaddr,
   input  logic        awvalid,
   output logic        awready,
   input  logic [31:0] wdata,
   input  logic [3:0]  wstrb,
   input  logic        wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  logic        bready,
   input  logic [7:0]  araddr,
   input  logic        arvalid,
   output logic        arready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rvalid,
   input  logic        rready,
   coreCtrlIf.regs     ctrl,
   input  lcdNibbleT   lastNibble,
   input  logic        lastRs,
   input  logic [7:0]  nibbleCount
);

   logic        awHeld;
   logic        wHeld;
   logic [7:0]  awAddrQ;
   logic [31:0] wDataQ;
   logic [3:0]  wStrbQ;
   logic        awHit;
   logic        wHit;
   logic        doWrite;
   logic [7:0]  wrAddr;
   logic [31:0] wrData;
   logic [3:0]  wrStrb;
   logic        ctrlWr;
   logic        run;
   logic        restart;
   logic [31:0] rdNext;

   function automatic logic mapped(logic [7:0] a);
      return a[7:4] == 4'h0 && a[1:0] == 2'b00;
   endfunction

   assign awready = !awHeld && !bvalid;
   assign wready = !wHeld && !bvalid;
   assign arready = !rvalid;
   assign awHit = awvalid && awready;
   assign wHit = wvalid && wready;

   // Address and data may come in either order
   assign wrAddr = awHeld ? awAddrQ : awaddr;
   assign wrData = wHeld ? wDataQ : wdata;
   assign wrStrb = wHeld ? wStrbQ : wstrb;
   assign doWrite = (awHeld || awHit) && (wHeld || wHit);
   assign ctrlWr = doWrite && mapped(wrAddr) && wrAddr[3:0] == CTRL && wrStrb[0];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         awHeld <= 1'b0;
         wHeld <= 1'b0;
         bvalid <= 1'b0;
         rvalid <= 1'b0;
         run <= 1'b1;
         restart <= 1'b0;
      end else begin
         restart <= ctrlWr && wrData[1];
         if (ctrlWr) begin
            run <= wrData[0];
         end
         if (doWrite) begin
            awHeld <= 1'b0;
            wHeld <= 1'b0;
            bvalid <= 1'b1;
         end else begin
            if (awHit) begin
               awHeld <= 1'b1;
            end
            if (wHit) begin
               wHeld <= 1'b1;
            end
            if (bvalid && bready) begin
               bvalid <= 1'b0;
            end
         end
         if (arvalid && arready) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
      end
   end

   always_comb begin
      rdNext = '0;
      case (araddr[3:0])
         CTRL:     rdNext = {31'b0, run};
         STATUS:   rdNext = {16'b0, ctrl.pc, 7'b0, ctrl.halted};
         LASTNIB:  rdNext = {27'b0, lastRs, lastNibble};
         NIBCOUNT: rdNext = {24'b0, nibbleCount};
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (awHit) begin
         awAddrQ <= awaddr;
      end
      if (wHit) begin
         wDataQ <= wdata;
         wStrbQ <= wstrb;
      end
      if (doWrite) begin
         bresp <= mapped(wrAddr) ? RespOkay : RespSlvErr;
      end
      if (arvalid && arready) begin
         rdata <= mapped(araddr) ? rdNext : '0;
         rresp <= mapped(araddr) ? RespOkay : RespSlvErr;
      end
   end

   assign ctrl.run = run;
   assign ctrl.restart = restart;

endmodule

/* verilog/lcdCtrlTop.sv */
`timescale 1ns/1ps

module lcdCtrlTop import isaPkg::*, lcdPkg::*; #(
   parameter int WaitShift = 0,
   parameter int StackDepth = 4
) (
   input  logic        clk,
   input  logic        rstN,
   input  logic [7:0]  awaddr,
   input  logic        awvalid,
   output logic        awready,
   input  logic [31:0] wdata,
   input  logic [3:0]  wstrb,
   input  logic        wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  logic        bready,
   input  logic [7:0]  araddr,
   input  logic        arvalid,
   output logic        arready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rvalid,
   input  logic        rready,
   output logic        lcdRs,
   output logic        lcdE,
   output lcdNibbleT   lcdD
);

   logic [$clog2(RomDepth)-1:0] romAddr;
   instrT                       romInstr;
   lcdNibbleT                   lastNibble;
   logic                        lastRs;
   logic [7:0]                  nibbleCount;

   lcdBusIf lcdBus ();
   coreCtrlIf ctrl ();

   programRom #(.WaitShift(WaitShift)) uRom (
      .address(romAddr),
      .instr  (romInstr)
   );

   seqCore #(.StackDepth(StackDepth)) uCore (
      .clk   (clk),
      .rstN  (rstN),
      .pcOut (romAddr),
      .instr (romInstr),
      .lcdBus(lcdBus.core),
      .ctrl  (ctrl.core)
   );

   lcdPort uPort (
      .clk        (clk),
      .rstN       (rstN),
      .lcdBus     (lcdBus.port),
      .lcdRs      (lcdRs),
      .lcdE       (lcdE),
      .lcdD       (lcdD),
      .lastNibble (lastNibble),
      .lastRs     (lastRs),
      .nibbleCount(nibbleCount)
   );

   ctrlRegs uRegs (
      .clk        (clk),
      .rstN       (rstN),
      .awaddr     (awaddr),
      .awvalid    (awvalid),
      .awready    (awready),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .wvalid     (wvalid),
      .wready     (wready),
      .bresp      (bresp),
      .bvalid     (bvalid),
      .bready     (bready),
      .araddr     (araddr),
      .arvalid    (arvalid),
      .arready    (arready),
      .rdata      (rdata),
      .rresp      (rresp),
      .rvalid     (rvalid),
      .rready     (rready),
      .ctrl       (ctrl.regs),
      .lastNibble (lastNibble),
      .lastRs     (lastRs),
      .nibbleCount(nibbleCount)
   );

endmodule

/* tests/lcdCtrlTb.sv */
`timescale 1ns/1ps

module lcdCtrlTb import lcdPkg::*; ();

   localparam int NumNibbles = 32;
   localparam int ProgCycles = 2000;   // One scaled program run, rounded up
   localparam int PauseCycles = 200;
   localparam int PauseAt = 14;
   localparam int WatchdogCycles = 4 * (2 * ProgCycles + PauseCycles);
   localparam int HandshakeLimit = 64;
   localparam int FlagAwReady = 0;
   localparam int FlagWReady = 1;
   localparam int FlagArReady = 2;
   localparam int FlagBValid = 3;
   localparam int FlagRValid = 4;

   logic        clk = 1'b0;
   logic        rstN;
   logic [7:0]  awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;
   logic [7:0]  araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;
   logic        lcdRs;
   logic        lcdE;
   lcdNibbleT   lcdD;

   logic [31:0] patMem [NumNibbles + 3];   // Nibbles, then STATUS, NIBCOUNT, LASTNIB
   logic [31:0] lfsr = 32'h7e7f_0b51;
   int          edgeCount = 0;   // All E falling edges since reset
   int          runBase = 0;     // Edge count when the current run began
   logic        eLast = 1'b0;

   lcdCtrlTop #(.WaitShift(10)) u_dut (.*);

   initial begin
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] randBits(input int n);
      logic [31:0] r;
      logic        outBit;
      r = '0;
      for (int i = 0; i < n; i++) begin
         outBit = lfsr[0];
         lfsr = lfsr >> 1;
         if (outBit) begin
            lfsr = lfsr ^ 32'h8020_0003;
         end
         r = {r[30:0], outBit};
      end
      return r;
   endfunction

   task automatic failRun(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic checkNibble(input lcdNibbleT gotNib, input bit gotRs,
                              input lcdNibbleT expNib, input bit expRs, input string what);
      if (gotNib !== expNib || gotRs !== expRs) begin
         failRun($sformatf("MISMATCH at %0t ns: %s got RS %0b nibble %h, expected RS %0b nibble %h",
                           $time, what, gotRs, gotNib, expRs, expNib));
      end
   endtask

   task automatic checkWord(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         failRun($sformatf("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic checkResp(input logic [1:0] got, input logic [1:0] exp, input string what);
      if (got !== exp) begin
         failRun($sformatf("MISMATCH at %0t ns: %s response %b, expected %b",
                           $time, what, got, exp));
      end
   endtask

   function automatic logic flagHigh(input int which);
      case (which)
         FlagAwReady: return awready;
         FlagWReady:  return wready;
         FlagArReady: return arready;
         FlagBValid:  return bvalid;
         default:     return rvalid;
      endcase
   endfunction

   // Looks mid low phase, handshake then lands on the next rising edge
   task automatic waitFlag(input int which, input string what);
      int n;
      n = 0;
      #1;
      while (flagHigh(which) !== 1'b1) begin
         @(negedge clk);
         #1;
         n++;
         if (n > HandshakeLimit) begin
            failRun($sformatf("AXI %s handshake did not complete within %0d cycles",
                              what, HandshakeLimit));
         end
      end
   endtask

   task automatic writeReg(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
      int dAw;
      int dW;
      int dB;
      dAw = int'(randBits(2));   // Delays also set the AW/W order
      dW = int'(randBits(2));
      dB = int'(randBits(2));
      fork
         begin
            repeat (dAw) @(negedge clk);
            awaddr = addr;
            awvalid = 1'b1;
            waitFlag(FlagAwReady, "write address");
            @(negedge clk);
            awvalid = 1'b0;
         end
         begin
            repeat (dW) @(negedge clk);
            wdata = data;
            wstrb = 4'hF;
            wvalid = 1'b1;
            waitFlag(FlagWReady, "write data");
            @(negedge clk);
            wvalid = 1'b0;
         end
      join
      repeat (dB) @(negedge clk);
      bready = 1'b1;
      waitFlag(FlagBValid, "write response");
      resp = bresp;
      @(negedge clk);
      bready = 1'b0;
   endtask

   task automatic readReg(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
      int dAr;
      int dR;
      dAr = int'(randBits(2));
      dR = int'(randBits(2));
      repeat (dAr) @(negedge clk);
      araddr = addr;
      arvalid = 1'b1;
      waitFlag(FlagArReady, "read address");
      @(negedge clk);
      arvalid = 1'b0;
      repeat (dR) @(negedge clk);
      rready = 1'b1;
      waitFlag(FlagRValid, "read data");
      data = rdata;
      resp = rresp;
      @(negedge clk);
      rready = 1'b0;
   endtask

   task automatic waitHalted();
      logic [31:0] rd;
      logic [1:0]  resp;
      int          polls;
      rd = '0;
      polls = 0;
      while (rd[0] !== 1'b1) begin
         repeat (16) @(negedge clk);
         readReg({4'h0, STATUS}, rd, resp);
         checkResp(resp, RespOkay, "STATUS poll");
         polls++;
         if (polls > ProgCycles / 4) begin
            failRun("The core never reported halted in STATUS");
         end
      end
   endtask

   // NIBCOUNT is not cleared by restart, so it keeps growing per run
   task automatic checkFinal(input int runs);
      logic [31:0] rd;
      logic [1:0]  resp;
      checkWord(32'(edgeCount - runBase), NumNibbles, "E falling edges in this run");
      readReg({4'h0, STATUS}, rd, resp);
      checkResp(resp, RespOkay, "STATUS read");
      checkWord(rd, patMem[NumNibbles], "STATUS at halt");
      readReg({4'h0, NIBCOUNT}, rd, resp);
      checkResp(resp, RespOkay, "NIBCOUNT read");
      checkWord(rd, (patMem[NumNibbles + 1] * runs) & 32'hFF, "NIBCOUNT at halt");
      readReg({4'h0, LASTNIB}, rd, resp);
      checkResp(resp, RespOkay, "LASTNIB read");
      checkWord(rd, patMem[NumNibbles + 2], "LASTNIB at halt");
   endtask

   // Every falling edge of E must match the next pattern entry
   always @(negedge clk) begin
      if (rstN && eLast && !lcdE) begin
         if (edgeCount - runBase >= NumNibbles) begin
            failRun($sformatf("MISMATCH at %0t ns: extra E falling edge after %0d nibbles",
                              $time, NumNibbles));
         end else begin
            checkNibble(lcdD, lcdRs, patMem[edgeCount - runBase][3:0],
                        patMem[edgeCount - runBase][4],
                        $sformatf("nibble %0d", edgeCount - runBase));
         end
         edgeCount++;
      end
      eLast = lcdE;
   end

   initial begin
      repeat (WatchdogCycles) @(posedge clk);
      failRun($sformatf("Watchdog timeout, the tests did not finish within %0d cycles",
                        WatchdogCycles));
   end

   initial begin
      logic [31:0] rd;
      logic [31:0] cntBefore;
      logic [1:0]  resp;
      logic [7:0]  sel;
      lcdNibbleT   frozenD;
      logic        frozenRs;
      logic        frozenE;
      rstN = 1'b0;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      $readmemh("tests/lcdPatterns.txt", patMem);
      if (patMem[NumNibbles][0] !== 1'b1) begin
         failRun("The pattern file tests/lcdPatterns.txt is missing or incomplete");
      end
      repeat (10) @(negedge clk);
      rstN = 1'b1;

      // Random register traffic while the program runs
      repeat (8) begin
         sel = {4'h0, 2'(randBits(2)), 2'b00};
         if (randBits(1) == 32'd1) begin
            writeReg({4'h0, CTRL}, 32'h1, resp);
            checkResp(resp, RespOkay, "CTRL write");
         end else begin
            readReg(sel, rd, resp);
            checkResp(resp, RespOkay, "register read");
         end
      end
      writeReg(8'h10, 32'h0, resp);   // Would stop the core if it aliased CTRL
      checkResp(resp, RespSlvErr, "write to offset 0x10");
      readReg(8'h10, rd, resp);
      checkResp(resp, RespSlvErr, "read of offset 0x10");
      readReg({4'h0, CTRL}, rd, resp);
      checkResp(resp, RespOkay, "CTRL read");
      checkWord(rd, 32'h1, "CTRL after unmapped write");

      // Hold the core partway through
      wait (edgeCount >= PauseAt);
      @(negedge clk);
      writeReg({4'h0, CTRL}, 32'h0, resp);
      checkResp(resp, RespOkay, "CTRL write run 0");
      frozenD = lcdD;
      frozenRs = lcdRs;
      frozenE = lcdE;
      readReg({4'h0, NIBCOUNT}, cntBefore, resp);
      checkResp(resp, RespOkay, "NIBCOUNT read");
      repeat (PauseCycles) begin
         @(negedge clk);
         checkNibble(lcdD, lcdRs, frozenD, frozenRs, "pins while held");
         checkWord({31'b0, lcdE}, {31'b0, frozenE}, "E while held");
      end
      readReg({4'h0, NIBCOUNT}, rd, resp);
      checkResp(resp, RespOkay, "NIBCOUNT read");
      checkWord(rd, cntBefore, "NIBCOUNT while held");
      writeReg({4'h0, CTRL}, 32'h1, resp);
      checkResp(resp, RespOkay, "CTRL write run 1");

      waitHalted();
      checkFinal(1);

      // Restart replays the whole program
      runBase = edgeCount;
      writeReg({4'h0, CTRL}, 32'h3, resp);
      checkResp(resp, RespOkay, "CTRL restart write");
      readReg({4'h0, STATUS}, rd, resp);
      checkResp(resp, RespOkay, "STATUS read");
      checkWord(rd & 32'h1, 32'h0, "halted after restart");
      waitHalted();
      checkFinal(2);

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

/* tests/lcdPatterns.txt */
// One E falling edge per line, high digit is RS and low digit is the nibble
// The last three words are the final STATUS, NIBCOUNT and LASTNIB reads
03   // Power-on wake nibbles
03
03
02   // Switch to 4-bit bus
02   // Function set 28
08
00   // Entry mode 06
06
00   // Display on 0C
0C
00   // Clear 01
01
14   // H 48
18
14   // O 4F
1F
14   // L 4C
1C
14   // A 41
11
12   // Space 20
10
14   // M 4D
1D
15   // U 55
15
14   // N 4E
1E
14   // D 44
14
14   // O 4F
1F
00003301   // STATUS with halted set and PC at exit label 51
00000020   // NIBCOUNT after one run
0000001F   // LASTNIB with RS 1 and nibble F

/* vlog.f */
verilog/isaPkg.sv
verilog/lcdPkg.sv
verilog/lcdBusIf.sv
verilog/coreCtrlIf.sv
verilog/programRom.sv
verilog/seqCore.sv
verilog/lcdPort.sv
verilog/ctrlRegs.sv
verilog/lcdCtrlTop.sv
tests/lcdCtrlTb.sv

/* Makefile */
# Verilator build for the LCD sequencer testbench

TOOL       = verilator
TOP        = lcdCtrlTb
FILELIST   = vlog.f
FLAGS      = --timing --top-module $(TOP)
SIM_FLAGS  = --binary -j 0
LINT_FLAGS = --lint-only
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) $(FLAGS) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
